// File: div_pkg.sv
// Shared widths, FSM states, quotient digit codes and the leading-zero count used by the divider
package div_pkg;

	// ========================================
	// Widths
	// ========================================
	// Operand and result width
	localparam int DATA_W = 32;
	// Leading-zero count of one operand
	localparam int LZC_W = 5;
	// Sign bit, integer bit, data bits and fraction guard bits of the carry-save remainder
	localparam int REM_W = DATA_W + 4;
	// Holds the iteration count minus one, so up to 16 iterations
	localparam int ITER_W = 4;
	// Divisor bits after the leading one that pick a table row
	localparam int DIVR_IDX_W = 3;
	// Truncated estimate of the shifted remainder, 3 integer and 4 fraction bits
	localparam int EST_W = 7;

	// ========================================
	// Enumerations
	// ========================================
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_PRE  = 2'd1,
		ST_ITER = 2'd2,
		ST_POST = 2'd3
	} div_state_e;

	// Two's complement codes, so the digit value is the code read as signed
	typedef enum logic [2:0] {
		DIG_NEG2 = 3'b110,
		DIG_NEG1 = 3'b111,
		DIG_ZERO = 3'b000,
		DIG_POS1 = 3'b001,
		DIG_POS2 = 3'b010
	} quo_dig_e;

	// Leading zeros of a data word; an all-zero word gives 0 and is flagged elsewhere
	function automatic logic [LZC_W-1:0] lzc(input logic [DATA_W-1:0] val);
		logic [LZC_W-1:0] cnt;
		logic found;
		cnt = '0;
		found = 1'b0;
		for (int i = DATA_W - 1; i >= 0; i--) begin
			if (!found && val[i]) begin
				found = 1'b1;
				cnt = LZC_W'(DATA_W - 1 - i);
			end
		end
		return cnt;
	endfunction

endpackage

// File: div_qds.sv
// Radix-4 quotient digit selection over -2..+2 from the remainder estimate and divisor row
`timescale 1ns/1ps

module div_qds (
	input  logic [div_pkg::EST_W-1:0]      est_i,
	input  logic [div_pkg::DIVR_IDX_W-1:0] divr_idx_i,
	output div_pkg::quo_dig_e              dig_o
);
	import div_pkg::*;

	logic signed [EST_W-1:0] est;
	logic signed [EST_W-1:0] m_pos2;
	logic signed [EST_W-1:0] m_pos1;
	logic signed [EST_W-1:0] m_zero;
	logic signed [EST_W-1:0] m_neg1;

	assign est = est_i;

	// ========================================
	// Threshold table, units of 1/16
	// ========================================
	// Row i covers divisor [(8+i)/16, (9+i)/16)
	always_comb begin
		case (divr_idx_i)
			3'd0: begin
				m_pos2 = 7'sd12; m_pos1 = 7'sd4; m_zero = -7'sd4; m_neg1 = -7'sd13;
			end
			3'd1: begin
				m_pos2 = 7'sd14; m_pos1 = 7'sd4; m_zero = -7'sd6; m_neg1 = -7'sd15;
			end
			3'd2: begin
				m_pos2 = 7'sd15; m_pos1 = 7'sd4; m_zero = -7'sd6; m_neg1 = -7'sd16;
			end
			3'd3: begin
				m_pos2 = 7'sd16; m_pos1 = 7'sd4; m_zero = -7'sd6; m_neg1 = -7'sd17;
			end
			3'd4: begin
				m_pos2 = 7'sd18; m_pos1 = 7'sd6; m_zero = -7'sd6; m_neg1 = -7'sd19;
			end
			3'd5: begin
				m_pos2 = 7'sd20; m_pos1 = 7'sd6; m_zero = -7'sd8; m_neg1 = -7'sd21;
			end
			3'd6: begin
				m_pos2 = 7'sd22; m_pos1 = 7'sd6; m_zero = -7'sd8; m_neg1 = -7'sd23;
			end
			default: begin
				m_pos2 = 7'sd24; m_pos1 = 7'sd8; m_zero = -7'sd8; m_neg1 = -7'sd25;
			end
		endcase
	end

	// Largest digit whose threshold the estimate reaches
	always_comb begin
		if (est >= m_pos2)
			dig_o = DIG_POS2;
		else if (est >= m_pos1)
			dig_o = DIG_POS1;
		else if (est >= m_zero)
			dig_o = DIG_ZERO;
		else if (est >= m_neg1)
			dig_o = DIG_NEG1;
		else
			dig_o = DIG_NEG2;
	end

endmodule

// File: div_prescale.sv
// Operand capture, magnitudes, normalization, iteration count and initial remainder for the divider
`timescale 1ns/1ps

module div_prescale (
	input  logic                        clk,
	input  logic                        capture_i,
	input  logic                        signed_op_i,
	input  logic [div_pkg::DATA_W-1:0]  dividend_i,
	input  logic [div_pkg::DATA_W-1:0]  divisor_i,
	output logic                        early_o,
	output logic [div_pkg::ITER_W-1:0]  iter_num_o,
	output logic                        div_zero_o,
	output logic                        quo_neg_o,
	output logic                        rem_neg_o,
	output logic [div_pkg::DATA_W-1:0]  divr_abs_o,
	output logic [div_pkg::DATA_W-1:0]  divr_norm_o,
	output logic [div_pkg::REM_W-1:0]   rem_init_o,
	output logic [div_pkg::DATA_W-1:0]  quo_init_o
);
	import div_pkg::*;

	logic                dvd_neg;
	logic                dvs_neg;
	logic [DATA_W-1:0]   dvd_abs_d;
	logic [DATA_W-1:0]   dvs_abs_d;
	logic [DATA_W-1:0]   dvd_abs_q;
	logic [DATA_W-1:0]   dvs_abs_q;
	logic                quo_neg_q;
	logic                rem_neg_q;
	logic [LZC_W-1:0]    dvd_lzc;
	logic [LZC_W-1:0]    dvs_lzc;
	logic [LZC_W-1:0]    lzc_diff;
	logic [DATA_W-1:0]   dvd_norm;
	logic [DATA_W-1:0]   dvd_early;
	logic [REM_W-1:0]    rem_align;
	logic [REM_W-1:0]    divr_full;
	logic [REM_W-1:0]    divr_half;
	logic                pre_digit;

	// ========================================
	// Capture on accepted start
	// ========================================
	assign dvd_neg = signed_op_i & dividend_i[DATA_W-1];
	assign dvs_neg = signed_op_i & divisor_i[DATA_W-1];
	assign dvd_abs_d = dvd_neg ? -dividend_i : dividend_i;
	assign dvs_abs_d = dvs_neg ? -divisor_i : divisor_i;

	always_ff @(posedge clk) begin
		if (capture_i) begin
			dvd_abs_q <= dvd_abs_d;
			dvs_abs_q <= dvs_abs_d;
			// Zero divisor returns all ones, so keep that quotient positive
			quo_neg_q <= (dvd_neg ^ dvs_neg) & (divisor_i != '0);
			rem_neg_q <= dvd_neg;
		end
	end

	assign quo_neg_o = quo_neg_q;
	assign rem_neg_o = rem_neg_q;
	assign divr_abs_o = dvs_abs_q;

	// ========================================
	// Normalize and count
	// ========================================
	assign dvd_lzc = lzc(dvd_abs_q);
	assign dvs_lzc = lzc(dvs_abs_q);
	// Never wraps when the early flag is low
	assign lzc_diff = dvs_lzc - dvd_lzc;

	assign div_zero_o = (dvs_abs_q == '0);
	assign early_o = div_zero_o | (dvd_abs_q < dvs_abs_q);
	// floor((diff + 2) / 2) - 1
	assign iter_num_o = lzc_diff[LZC_W-1:1];

	assign dvd_norm = dvd_abs_q << dvd_lzc;
	assign divr_norm_o = dvs_abs_q << dvs_lzc;

	// Remainder has binary point below bit REM_W-3, divisor sits in [1/2, 1)
	// Odd difference takes one extra left bit so 2N digits span the quotient
	assign rem_align = lzc_diff[0] ? {3'b000, dvd_norm, 1'b0} : {4'b0000, dvd_norm};
	assign divr_full = {2'b00, divr_norm_o, 2'b00};
	assign divr_half = {3'b000, divr_norm_o, 1'b0};

	// Leading digit 1 pulls the start remainder inside +-2/3 of the divisor
	assign pre_digit = (rem_align >= divr_half);

	// Early result goes out through the same unscaling as an iterated one
	assign dvd_early = dvd_abs_q << dvs_lzc;

	always_comb begin
		if (early_o) begin
			rem_init_o = {2'b00, dvd_early, 2'b00};
			quo_init_o = div_zero_o ? '1 : '0;
		end else begin
			rem_init_o = pre_digit ? (rem_align - divr_full) : rem_align;
			quo_init_o = {{(DATA_W-1){1'b0}}, pre_digit};
		end
	end

endmodule

// File: div_iter.sv
// Carry-save radix-4 SRT remainder recurrence with on-the-fly quotient conversion
`timescale 1ns/1ps

module div_iter (
	input  logic                       clk,
	input  logic                       load_i,
	input  logic                       step_i,
	input  logic [div_pkg::DATA_W-1:0] divr_norm_i,
	input  logic [div_pkg::REM_W-1:0]  rem_init_i,
	input  logic [div_pkg::DATA_W-1:0] quo_init_i,
	output logic [div_pkg::REM_W-1:0]  rem_s_o,
	output logic [div_pkg::REM_W-1:0]  rem_c_o,
	output logic [div_pkg::DATA_W-1:0] quo_o,
	output logic [div_pkg::DATA_W-1:0] quo_m1_o
);
	import div_pkg::*;

	logic [REM_W-1:0]  rem_s_q;
	logic [REM_W-1:0]  rem_c_q;
	logic [DATA_W-1:0] quo_q;
	logic [DATA_W-1:0] quo_m1_q;
	logic [EST_W-1:0]  est;
	quo_dig_e          dig;
	logic [REM_W-1:0]  divr_f;
	logic [REM_W-1:0]  mult;
	logic [REM_W-1:0]  rem_s_sh;
	logic [REM_W-1:0]  rem_c_sh;
	logic [REM_W-1:0]  maj;
	logic [REM_W-1:0]  rem_s_nxt;
	logic [REM_W-1:0]  rem_c_nxt;
	logic [DATA_W-1:0] quo_nxt;
	logic [DATA_W-1:0] quo_m1_nxt;

	// ========================================
	// Digit selection
	// ========================================
	// Bits below the sign give 4w in 1/16 units once summed
	assign est = rem_s_q[REM_W-2 -: EST_W] + rem_c_q[REM_W-2 -: EST_W];

	div_qds i_div_qds (
		.est_i      (est),
		.divr_idx_i (divr_norm_i[DATA_W-2 -: DIVR_IDX_W]),
		.dig_o      (dig)
	);

	// ========================================
	// Remainder update 4w - q*d
	// ========================================
	assign divr_f = {2'b00, divr_norm_i, 2'b00};

	// Positive digits subtract: inverted multiple here, +1 rides in the carry LSB
	always_comb begin
		case (dig)
			DIG_POS2: mult = ~(divr_f << 1);
			DIG_POS1: mult = ~divr_f;
			DIG_NEG1: mult = divr_f;
			DIG_NEG2: mult = divr_f << 1;
			default:  mult = '0;
		endcase
	end

	assign rem_s_sh = rem_s_q << 2;
	assign rem_c_sh = rem_c_q << 2;
	assign rem_s_nxt = rem_s_sh ^ rem_c_sh ^ mult;
	assign maj = (rem_s_sh & rem_c_sh) | (rem_s_sh & mult) | (rem_c_sh & mult);
	assign rem_c_nxt = {maj[REM_W-2:0], (dig == DIG_POS1) || (dig == DIG_POS2)};

	// ========================================
	// On-the-fly conversion
	// ========================================
	// quo_m1 always equals quo - 1, so negative digits borrow from it
	always_comb begin
		case (dig)
			DIG_POS2: begin
				quo_nxt    = {quo_q[DATA_W-3:0], 2'b10};
				quo_m1_nxt = {quo_q[DATA_W-3:0], 2'b01};
			end
			DIG_POS1: begin
				quo_nxt    = {quo_q[DATA_W-3:0], 2'b01};
				quo_m1_nxt = {quo_q[DATA_W-3:0], 2'b00};
			end
			DIG_NEG1: begin
				quo_nxt    = {quo_m1_q[DATA_W-3:0], 2'b11};
				quo_m1_nxt = {quo_m1_q[DATA_W-3:0], 2'b10};
			end
			DIG_NEG2: begin
				quo_nxt    = {quo_m1_q[DATA_W-3:0], 2'b10};
				quo_m1_nxt = {quo_m1_q[DATA_W-3:0], 2'b01};
			end
			default: begin
				quo_nxt    = {quo_q[DATA_W-3:0], 2'b00};
				quo_m1_nxt = {quo_m1_q[DATA_W-3:0], 2'b11};
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (load_i) begin
			rem_s_q  <= rem_init_i;
			rem_c_q  <= '0;
			quo_q    <= quo_init_i;
			quo_m1_q <= quo_init_i - 1'b1;
		end else if (step_i) begin
			rem_s_q  <= rem_s_nxt;
			rem_c_q  <= rem_c_nxt;
			quo_q    <= quo_nxt;
			quo_m1_q <= quo_m1_nxt;
		end
	end

	assign rem_s_o = rem_s_q;
	assign rem_c_o = rem_c_q;
	assign quo_o = quo_q;
	assign quo_m1_o = quo_m1_q;

endmodule

// File: div_ctrl.sv
// Divider FSM with iteration down-counter and start/finish handshake strobes
`timescale 1ns/1ps

module div_ctrl (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start_valid_i,
	input  logic                       finish_ready_i,
	input  logic                       flush_i,
	input  logic                       early_i,
	input  logic [div_pkg::ITER_W-1:0] iter_num_i,
	output logic                       start_ready_o,
	output logic                       finish_valid_o,
	output logic                       capture_o,
	output logic                       load_o,
	output logic                       step_o
);
	import div_pkg::*;

	div_state_e        state_q;
	div_state_e        state_d;
	logic [ITER_W-1:0] cnt_q;
	logic              last_iter;

	assign last_iter = (cnt_q == '0);

	// ========================================
	// Next state
	// ========================================
	always_comb begin
		case (state_q)
			ST_IDLE: state_d = start_valid_i ? ST_PRE : ST_IDLE;
			ST_PRE:  state_d = early_i ? ST_POST : ST_ITER;
			ST_ITER: state_d = last_iter ? ST_POST : ST_ITER;
			ST_POST: state_d = finish_ready_i ? ST_IDLE : ST_POST;
			default: state_d = ST_IDLE;
		endcase
		// Flush wins over everything
		if (flush_i)
			state_d = ST_IDLE;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	// Loaded with N-1, so ITER lasts N cycles
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cnt_q <= '0;
		else if (state_q == ST_PRE)
			cnt_q <= iter_num_i;
		else if ((state_q == ST_ITER) && !last_iter)
			cnt_q <= cnt_q - 1'b1;
	end

	// Strobes decoded from state
	assign start_ready_o = (state_q == ST_IDLE);
	assign finish_valid_o = (state_q == ST_POST);
	assign capture_o = start_valid_i & start_ready_o;
	assign load_o = (state_q == ST_PRE);
	assign step_o = (state_q == ST_ITER);

endmodule

// File: div_post.sv
// Final remainder resolve, negative-remainder correction and sign fix-up of quotient and remainder
`timescale 1ns/1ps

module div_post (
	input  logic [div_pkg::REM_W-1:0]  rem_s_i,
	input  logic [div_pkg::REM_W-1:0]  rem_c_i,
	input  logic [div_pkg::DATA_W-1:0] quo_i,
	input  logic [div_pkg::DATA_W-1:0] quo_m1_i,
	input  logic [div_pkg::DATA_W-1:0] divr_abs_i,
	input  logic                       quo_neg_i,
	input  logic                       rem_neg_i,
	output logic [div_pkg::DATA_W-1:0] quotient_o,
	output logic [div_pkg::DATA_W-1:0] remainder_o
);
	import div_pkg::*;

	logic [LZC_W-1:0]  divr_lzc;
	logic [DATA_W-1:0] divr_norm;
	logic [REM_W-1:0]  divr_f;
	logic [REM_W-1:0]  rem_sum;
	logic              rem_is_neg;
	logic [REM_W-1:0]  rem_fix;
	logic [LZC_W:0]    rem_sh;
	logic [REM_W-1:0]  rem_scaled;
	logic [DATA_W-1:0] rem_mag;
	logic [DATA_W-1:0] quo_mag;

	// Same divisor scaling as the recurrence
	assign divr_lzc = lzc(divr_abs_i);
	assign divr_norm = divr_abs_i << divr_lzc;
	assign divr_f = {2'b00, divr_norm, 2'b00};

	// ========================================
	// Resolve and correct
	// ========================================
	assign rem_sum = rem_s_i + rem_c_i;
	assign rem_is_neg = rem_sum[REM_W-1];

	// A negative partial remainder adds d back and takes quo - 1
	assign rem_fix = rem_is_neg ? (rem_sum + divr_f) : rem_sum;
	assign quo_mag = rem_is_neg ? quo_m1_i : quo_i;

	// Undo divisor normalization plus the two fraction guard bits
	assign rem_sh = {1'b0, divr_lzc} + (LZC_W+1)'(2);
	assign rem_scaled = rem_fix >> rem_sh;
	assign rem_mag = rem_scaled[DATA_W-1:0];

	// ========================================
	// Signs
	// ========================================
	assign quotient_o = quo_neg_i ? -quo_mag : quo_mag;
	// Remainder follows dividend sign
	assign remainder_o = rem_neg_i ? -rem_mag : rem_mag;

endmodule

// File: div_top.sv
// Top level of the iterative radix-4 SRT integer divider with valid/ready start and finish ports
`timescale 1ns/1ps

module div_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start_valid_i,
	output logic                       start_ready_o,
	input  logic                       flush_i,
	input  logic                       signed_op_i,
	input  logic [div_pkg::DATA_W-1:0] dividend_i,
	input  logic [div_pkg::DATA_W-1:0] divisor_i,
	output logic                       finish_valid_o,
	input  logic                       finish_ready_i,
	output logic [div_pkg::DATA_W-1:0] quotient_o,
	output logic [div_pkg::DATA_W-1:0] remainder_o,
	output logic                       divisor_is_zero_o
);
	import div_pkg::*;

	logic              capture;
	logic              load;
	logic              step;
	logic              early;
	logic [ITER_W-1:0] iter_num;
	logic              quo_neg;
	logic              rem_neg;
	logic [DATA_W-1:0] divr_abs;
	logic [DATA_W-1:0] divr_norm;
	logic [REM_W-1:0]  rem_init;
	logic [DATA_W-1:0] quo_init;
	logic [REM_W-1:0]  rem_s;
	logic [REM_W-1:0]  rem_c;
	logic [DATA_W-1:0] quo;
	logic [DATA_W-1:0] quo_m1;

	div_ctrl i_div_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.start_valid_i  (start_valid_i),
		.finish_ready_i (finish_ready_i),
		.flush_i        (flush_i),
		.early_i        (early),
		.iter_num_i     (iter_num),
		.start_ready_o  (start_ready_o),
		.finish_valid_o (finish_valid_o),
		.capture_o      (capture),
		.load_o         (load),
		.step_o         (step)
	);

	div_prescale i_div_prescale (
		.clk         (clk),
		.capture_i   (capture),
		.signed_op_i (signed_op_i),
		.dividend_i  (dividend_i),
		.divisor_i   (divisor_i),
		.early_o     (early),
		.iter_num_o  (iter_num),
		.div_zero_o  (divisor_is_zero_o),
		.quo_neg_o   (quo_neg),
		.rem_neg_o   (rem_neg),
		.divr_abs_o  (divr_abs),
		.divr_norm_o (divr_norm),
		.rem_init_o  (rem_init),
		.quo_init_o  (quo_init)
	);

	div_iter i_div_iter (
		.clk         (clk),
		.load_i      (load),
		.step_i      (step),
		.divr_norm_i (divr_norm),
		.rem_init_i  (rem_init),
		.quo_init_i  (quo_init),
		.rem_s_o     (rem_s),
		.rem_c_o     (rem_c),
		.quo_o       (quo),
		.quo_m1_o    (quo_m1)
	);

	div_post i_div_post (
		.rem_s_i     (rem_s),
		.rem_c_i     (rem_c),
		.quo_i       (quo),
		.quo_m1_i    (quo_m1),
		.divr_abs_i  (divr_abs),
		.quo_neg_i   (quo_neg),
		.rem_neg_i   (rem_neg),
		.quotient_o  (quotient_o),
		.remainder_o (remainder_o)
	);

endmodule

// File: div_properties.sv
// Handshake and FSM assertions for the divider controller, bound into div_ctrl
`timescale 1ns/1ps

module div_properties (
	input logic               clk,
	input logic               rst_n,
	input logic               flush_i,
	input logic               finish_ready_i,
	input logic               start_ready_i,
	input logic               finish_valid_i,
	input div_pkg::div_state_e state_i
);
	import div_pkg::*;

	// Number of assertion failures seen so far
	int fail_cnt = 0;

	// Start and finish sides are never open at once
	a_ready_valid_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(start_ready_i && finish_valid_i))
		else begin
			$error("start_ready_o and finish_valid_o high together");
			fail_cnt++;
		end

	// Flush lands in IDLE one edge later
	a_flush_idle: assert property (@(posedge clk) disable iff (!rst_n)
		flush_i |=> (state_i == ST_IDLE))
		else begin
			$error("flush did not return the FSM to IDLE");
			fail_cnt++;
		end

	// Result held until taken or flushed
	a_post_hold: assert property (@(posedge clk) disable iff (!rst_n)
		((state_i == ST_POST) && !finish_ready_i && !flush_i) |=> (state_i == ST_POST))
		else begin
			$error("FSM left POST without finish_ready_i or flush");
			fail_cnt++;
		end

endmodule

bind div_ctrl div_properties i_div_properties (
	.clk            (clk),
	.rst_n          (rst_n),
	.flush_i        (flush_i),
	.finish_ready_i (finish_ready_i),
	.start_ready_i  (start_ready_o),
	.finish_valid_i (finish_valid_o),
	.state_i        (state_q)
);

// File: div_checker.sv
// Divider scoreboard: snapshots accepted operands, models the result and checks every transfer
`timescale 1ns/1ps

module div_checker (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start_valid_i,
	input  logic                       start_ready_i,
	input  logic                       flush_i,
	input  logic                       signed_op_i,
	input  logic [div_pkg::DATA_W-1:0] dividend_i,
	input  logic [div_pkg::DATA_W-1:0] divisor_i,
	input  logic                       finish_valid_i,
	input  logic                       finish_ready_i,
	input  logic [div_pkg::DATA_W-1:0] quotient_i,
	input  logic [div_pkg::DATA_W-1:0] remainder_i,
	input  logic                       div_zero_i,
	output int                         val_err_o,
	output int                         proto_err_o,
	output int                         xfer_cnt_o
);
	import div_pkg::*;

	int                val_err = 0;
	int                proto_err = 0;
	int                xfer_cnt = 0;
	logic              pending;
	logic              flushed;
	logic              hold_valid;
	logic [DATA_W-1:0] exp_q;
	logic [DATA_W-1:0] exp_r;
	logic              exp_dz;
	logic [DATA_W-1:0] hold_q;
	logic [DATA_W-1:0] hold_r;
	logic              hold_dz;

	assign val_err_o = val_err;
	assign proto_err_o = proto_err;
	assign xfer_cnt_o = xfer_cnt;

	// ========================================
	// Reference model
	// ========================================
	// Truncating division with the remainder taking the dividend sign
	function automatic void compute_expected(input logic sgn,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
		output logic [DATA_W-1:0] q, output logic [DATA_W-1:0] r, output logic dz);
		dz = (b == '0);
		if (dz) begin
			q = '1;
			r = a;
		end else if (sgn && (a == {1'b1, {(DATA_W-1){1'b0}}}) && (b == '1)) begin
			// Overflow wraps to the most negative value
			q = a;
			r = '0;
		end else if (sgn) begin
			q = $signed(a) / $signed(b);
			r = $signed(a) % $signed(b);
		end else begin
			q = a / b;
			r = a % b;
		end
	endfunction

	task automatic check_value(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
			val_err++;
		end
	endtask

	// ========================================
	// Port monitor sampled on the rising edge
	// ========================================
	always @(posedge clk) begin
		if (!rst_n) begin
			pending = 1'b0;
			flushed = 1'b0;
			hold_valid = 1'b0;
		end else begin
			if (flushed && !start_ready_i) begin
				$display("At %0t start_ready_o did not return high after a flush", $time);
				proto_err++;
			end
			flushed = flush_i;

			// Under back-pressure the outputs stay frozen and no new start is offered
			if (finish_valid_i && start_ready_i) begin
				$display("At %0t start_ready_o and finish_valid_o were high together", $time);
				proto_err++;
			end
			if (finish_valid_i && hold_valid) begin
				check_value("quotient_o (held)", quotient_i, hold_q);
				check_value("remainder_o (held)", remainder_i, hold_r);
				check_value("divisor_is_zero_o (held)", 32'(div_zero_i), 32'(hold_dz));
			end

			if (flush_i) begin
				pending = 1'b0;
			end else if (finish_valid_i && finish_ready_i) begin
				if (!pending) begin
					$display("At %0t a result was handed over with no division in flight", $time);
					proto_err++;
				end else begin
					check_value("quotient_o", quotient_i, exp_q);
					check_value("remainder_o", remainder_i, exp_r);
					check_value("divisor_is_zero_o", 32'(div_zero_i), 32'(exp_dz));
				end
				pending = 1'b0;
				xfer_cnt++;
			end

			hold_valid = finish_valid_i && !finish_ready_i && !flush_i;
			hold_q = quotient_i;
			hold_r = remainder_i;
			hold_dz = div_zero_i;

			// Model result of an accepted start is kept until the transfer
			if (start_valid_i && start_ready_i && !flush_i) begin
				if (pending) begin
					$display("At %0t a start was accepted while a division was in flight", $time);
					proto_err++;
				end
				compute_expected(signed_op_i, dividend_i, divisor_i, exp_q, exp_r, exp_dz);
				pending = 1'b1;
			end
		end
	end

endmodule

// File: tb_div.sv
// Testbench top for the SRT divider: clock, reset, random operations with flush and back-pressure
`timescale 1ns/1ps

module tb_div;
	import div_pkg::*;

	localparam int N_OPS = 400;
	localparam int SEED = 47589;
	localparam int RST_CYC = 4;
	// Worst case per operation is about 24 cycles
	localparam int TIMEOUT_CYC = N_OPS * 25 + 100;

	logic              clk;
	logic              rst_n;
	logic              start_valid_i;
	logic              flush_i;
	logic              signed_op_i;
	logic [DATA_W-1:0] dividend_i;
	logic [DATA_W-1:0] divisor_i;
	logic              finish_ready_i;
	logic              start_ready_o;
	logic              finish_valid_o;
	logic [DATA_W-1:0] quotient_o;
	logic [DATA_W-1:0] remainder_o;
	logic              divisor_is_zero_o;

	int                val_err;
	int                proto_err;
	int                assert_err;
	int                xfer_cnt;
	int                done_cnt;
	int                cycle_cnt = 0;
	int                sel;
	logic              op_sgn;
	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;

	// ========================================
	// Clock and timeout
	// ========================================
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYC) begin
			$display("Timeout: DUT gave no response within %0d cycles", TIMEOUT_CYC);
			$display("test failed");
			$finish;
		end
	end

	div_top i_div_top (
		.clk               (clk),
		.rst_n             (rst_n),
		.start_valid_i     (start_valid_i),
		.start_ready_o     (start_ready_o),
		.flush_i           (flush_i),
		.signed_op_i       (signed_op_i),
		.dividend_i        (dividend_i),
		.divisor_i         (divisor_i),
		.finish_valid_o    (finish_valid_o),
		.finish_ready_i    (finish_ready_i),
		.quotient_o        (quotient_o),
		.remainder_o       (remainder_o),
		.divisor_is_zero_o (divisor_is_zero_o)
	);

	div_checker i_div_checker (
		.clk             (clk),
		.rst_n           (rst_n),
		.start_valid_i   (start_valid_i),
		.start_ready_i   (start_ready_o),
		.flush_i         (flush_i),
		.signed_op_i     (signed_op_i),
		.dividend_i      (dividend_i),
		.divisor_i       (divisor_i),
		.finish_valid_i  (finish_valid_o),
		.finish_ready_i  (finish_ready_i),
		.quotient_i      (quotient_o),
		.remainder_i     (remainder_o),
		.div_zero_i      (divisor_is_zero_o),
		.val_err_o       (val_err),
		.proto_err_o     (proto_err),
		.xfer_cnt_o      (xfer_cnt)
	);

	// Failures of the bound controller assertions
	assign assert_err = i_div_top.i_div_ctrl.i_div_properties.fail_cnt;

	// ========================================
	// Stimulus helpers
	// ========================================
	// Inputs change 2 ns after the rising edge
	task automatic next_edge();
		@(posedge clk);
		#2;
	endtask

	// Operand classes zero divisor, overflow, small dividend, powers of two and random
	task automatic make_operands(input int kind, output logic sgn,
		output logic [DATA_W-1:0] a, output logic [DATA_W-1:0] b);
		logic [DATA_W-1:0] mag;
		sgn = 1'($urandom % 2);
		a = $urandom >> ($urandom % 32);
		b = $urandom >> ($urandom % 32);
		case (kind)
			0: b = '0;
			1: begin
				sgn = 1'b1;
				a = {1'b1, {(DATA_W-1){1'b0}}};
				b = '1;
			end
			2: begin
				// Magnitude kept below 2^31 so a signed negate stays exact
				mag = ($urandom >> (1 + $urandom % 16)) | 2;
				a = $urandom % mag;
				b = mag;
				if (sgn && ($urandom % 2))
					a = -a;
				if (sgn && ($urandom % 2))
					b = -b;
			end
			3: begin
				b = 32'd1 << ($urandom % 32);
				if (sgn && ($urandom % 2))
					b = -b;
			end
			default: begin
				if (sgn && ($urandom % 4 == 0))
					a = -a;
				if (sgn && ($urandom % 4 == 0))
					b = -b;
			end
		endcase
	endtask

	// Present one start and hold it until accepted
	task automatic launch(input logic sgn, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b);
		while (!start_ready_o)
			next_edge();
		start_valid_i = 1'b1;
		signed_op_i = sgn;
		dividend_i = a;
		divisor_i = b;
		next_edge();
		start_valid_i = 1'b0;
	endtask

	// Wait for the result, stall 0..4 cycles, then take it
	task automatic take_result();
		int stall;
		stall = $urandom % 5;
		while (!finish_valid_o)
			next_edge();
		repeat (stall) next_edge();
		finish_ready_i = 1'b1;
		next_edge();
		finish_ready_i = 1'b0;
	endtask

	// Flush somewhere between PRE and a waiting POST
	// Ready stays high one cycle past the flush so a missed flush hands over a result
	task automatic flush_late();
		int wait_cyc;
		wait_cyc = $urandom % 6;
		repeat (wait_cyc) next_edge();
		flush_i = 1'b1;
		finish_ready_i = 1'b1;
		next_edge();
		flush_i = 1'b0;
		next_edge();
		finish_ready_i = 1'b0;
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		start_valid_i = 1'b0;
		flush_i = 1'b0;
		signed_op_i = 1'b0;
		dividend_i = '0;
		divisor_i = '0;
		finish_ready_i = 1'b0;
		done_cnt = 0;
		repeat (RST_CYC) @(posedge clk);
		#2;
		rst_n = 1'b1;
		next_edge();

		for (int i = 0; i < N_OPS; i++) begin
			// First five operations visit each class once
			sel = (i < 5) ? i : int'($urandom % 16);
			make_operands(sel, op_sgn, op_a, op_b);
			launch(op_sgn, op_a, op_b);
			if (sel == 4) begin
				flush_late();
			end else begin
				take_result();
				done_cnt++;
			end
		end
		repeat (4) next_edge();

		if (xfer_cnt != done_cnt)
			$display("Finish transfers %0d do not match completed operations %0d",
				xfer_cnt, done_cnt);
		$display("Summary: value errors %0d, protocol errors %0d, assertion errors %0d, transfers %0d",
			val_err, proto_err, assert_err, xfer_cnt);
		if (val_err == 0 && proto_err == 0 && assert_err == 0 && xfer_cnt == done_cnt) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: verilog.f
div_pkg.sv
div_qds.sv
div_prescale.sv
div_iter.sv
div_ctrl.sv
div_post.sv
div_top.sv
div_properties.sv
div_checker.sv
tb_div.sv

// File: Bender.yml
package:
  name: div_srt

sources:
  # RTL in compile order
  - div_pkg.sv
  - div_qds.sv
  - div_prescale.sv
  - div_iter.sv
  - div_ctrl.sv
  - div_post.sv
  - div_top.sv
  # Testbench
  - target: simulation
    files:
      - div_properties.sv
      - div_checker.sv
      - tb_div.sv
